// ==== src/rvCorePkg.sv ====
// Core widths, opcodes, ALU codes, instruction word union, stage register structs, byte swap
`default_nettype none

package rvCorePkg;

    // ==================================================
    // Widths and opcodes
    // ==================================================
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int WORD_ADDR_W = 30;

    // Opcode bits 6..2, bits 1..0 must read 2'b11
    localparam logic [4:0] OPC_RTYPE = 5'b01100;
    localparam logic [4:0] OPC_ITYPE = 5'b00100;
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;

    typedef enum logic [1:0] {
        ALU_CLASS_ADDR = 2'd0,
        ALU_CLASS_REG  = 2'd1,
        ALU_CLASS_IMM  = 2'd2
    } aluClass_e;

    // Encoded as {funct7 bit 5, funct3}
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SUB = 4'b1000,
        ALU_SLL = 4'b0001,
        ALU_SLT = 4'b0010,
        ALU_XOR = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_SRA = 4'b1101,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111
    } aluOp_e;

    // ==================================================
    // Instruction word views
    // ==================================================
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } rFields_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } iFields_t;

    typedef struct packed {
        logic [6:0]            immHi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            immLo;
        logic [6:0]            opcode;
    } sFields_t;

    typedef union packed {
        rFields_t rFields;
        iFields_t iFields;
        sFields_t sFields;
    } instWord_u;

    // ==================================================
    // Pipeline registers and ports
    // ==================================================
    typedef struct packed {
        logic      regWrite;
        logic      memToReg;
        logic      memRead;
        logic      memWrite;
        logic      aluSrc;
        aluClass_e aluClass;
    } ctrlSig_t;

    typedef struct packed {
        ctrlSig_t              ctrl;
        logic [XLEN-1:0]       rdata1;
        logic [XLEN-1:0]       rdata2;
        logic [XLEN-1:0]       imm;
        logic                  funct7Bit;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
    } idExReg_t;

    typedef struct packed {
        logic                  regWrite;
        logic                  memToReg;
        logic                  memRead;
        logic                  memWrite;
        logic [XLEN-1:0]       aluOut;
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] rd;
    } exMemReg_t;

    typedef struct packed {
        logic                  regWrite;
        logic                  memToReg;
        logic [XLEN-1:0]       aluOut;
        logic [XLEN-1:0]       loadData;
        logic [REG_ADDR_W-1:0] rd;
    } memWbReg_t;

    typedef struct packed {
        logic                   ren;
        logic                   wen;
        logic [WORD_ADDR_W-1:0] addr;
        logic [XLEN-1:0]        wdata;
    } dataReq_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wbPort_t;

    // Big-endian memory side, little-endian core side
    function automatic logic [XLEN-1:0] byteSwap(input logic [XLEN-1:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

endpackage

`default_nettype wire

// ==== src/fetchStage.sv ====
// Fetch stage: program counter, instruction byte swap, fetch/decode register
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               stall,
    output logic [rvCorePkg::WORD_ADDR_W-1:0] iAddr,
    input  wire  [rvCorePkg::XLEN-1:0]        iRdata,
    output rvCorePkg::instWord_u              instWord
);
    import rvCorePkg::*;

    logic [XLEN-1:0] pc;

    // Byte address, only sequential flow
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + XLEN'(4);
        end
    end

    assign iAddr = pc[XLEN-1:2];

    // Zero word decodes as a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instWord <= '0;
        end else if (!stall) begin
            instWord <= byteSwap(iRdata);
        end
    end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
// Register file: 31 writable registers, zero register, two read ports, one write port
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire rvCorePkg::wbPort_t          wb,
    input  wire  [rvCorePkg::REG_ADDR_W-1:0] rs1,
    input  wire  [rvCorePkg::REG_ADDR_W-1:0] rs2,
    output logic [rvCorePkg::XLEN-1:0]       rdata1,
    output logic [rvCorePkg::XLEN-1:0]       rdata2
);
    import rvCorePkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // No write-through, a write shows up one cycle later
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
// Decode stage: control decode, immediate generation, operand read, decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       stall,
    input  wire rvCorePkg::instWord_u instWord,
    input  wire rvCorePkg::wbPort_t   wb,
    output rvCorePkg::idExReg_t       idEx
);
    import rvCorePkg::*;

    ctrlSig_t        ctrl;
    logic [XLEN-1:0] iImm;
    logic [XLEN-1:0] sImm;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    idExReg_t        idExNext;

    // ==================================================
    // Control decode
    // ==================================================
    always_comb begin
        ctrl = '0;
        if (instWord.rFields.opcode[1:0] == 2'b11) begin
            case (instWord.rFields.opcode[6:2])
                OPC_RTYPE: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluClass = ALU_CLASS_REG;
                end
                OPC_ITYPE: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluClass = ALU_CLASS_IMM;
                end
                OPC_LOAD: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluClass = ALU_CLASS_ADDR;
                end
                OPC_STORE: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluClass = ALU_CLASS_ADDR;
                end
                default: begin
                    ctrl = '0;
                end
            endcase
        end
    end

    // Sign-extended immediates from the I and S views
    assign iImm = {{(XLEN-12){instWord.iFields.imm12[11]}}, instWord.iFields.imm12};
    assign sImm = {{(XLEN-12){instWord.sFields.immHi[6]}},
                   instWord.sFields.immHi, instWord.sFields.immLo};
    assign imm  = ctrl.memWrite ? sImm : iImm;

    regFile uRegFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb     (wb),
        .rs1    (instWord.rFields.rs1),
        .rs2    (instWord.rFields.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_comb begin
        idExNext.ctrl      = ctrl;
        idExNext.rdata1    = rdata1;
        idExNext.rdata2    = rdata2;
        idExNext.imm       = imm;
        idExNext.funct7Bit = instWord.rFields.funct7[5];
        idExNext.funct3    = instWord.rFields.funct3;
        idExNext.rd        = instWord.rFields.rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else if (!stall) begin
            idEx <= idExNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
// Execute stage: ALU control mapping, ALU, store data swap, execute/memory register
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      stall,
    input  wire rvCorePkg::idExReg_t idEx,
    output rvCorePkg::exMemReg_t     exMem
);
    import rvCorePkg::*;

    aluOp_e          aluOp;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [4:0]      shamt;
    logic [XLEN-1:0] aluOut;
    exMemReg_t       exMemNext;

    // ==================================================
    // ALU control
    // ==================================================
    always_comb begin
        aluOp = ALU_ADD;
        case (idEx.ctrl.aluClass)
            ALU_CLASS_REG: begin
                case ({idEx.funct7Bit, idEx.funct3})
                    4'b0000: aluOp = ALU_ADD;
                    4'b1000: aluOp = ALU_SUB;
                    4'b0001: aluOp = ALU_SLL;
                    4'b0010: aluOp = ALU_SLT;
                    4'b0100: aluOp = ALU_XOR;
                    4'b0101: aluOp = ALU_SRL;
                    4'b1101: aluOp = ALU_SRA;
                    4'b0110: aluOp = ALU_OR;
                    4'b0111: aluOp = ALU_AND;
                    default: aluOp = ALU_ADD;
                endcase
            end
            ALU_CLASS_IMM: begin
                // Bit 30 is part of the immediate except on right shifts
                case (idEx.funct3)
                    3'b000:  aluOp = ALU_ADD;
                    3'b001:  aluOp = ALU_SLL;
                    3'b010:  aluOp = ALU_SLT;
                    3'b100:  aluOp = ALU_XOR;
                    3'b101:  aluOp = idEx.funct7Bit ? ALU_SRA : ALU_SRL;
                    3'b110:  aluOp = ALU_OR;
                    3'b111:  aluOp = ALU_AND;
                    default: aluOp = ALU_ADD;
                endcase
            end
            default: begin
                // Load and store address
                aluOp = ALU_ADD;
            end
        endcase
    end

    // ==================================================
    // ALU
    // ==================================================
    assign opA   = idEx.rdata1;
    assign opB   = idEx.ctrl.aluSrc ? idEx.imm : idEx.rdata2;
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            ALU_ADD: aluOut = opA + opB;
            ALU_SUB: aluOut = opA - opB;
            ALU_SLL: aluOut = opA << shamt;
            ALU_SLT: aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_XOR: aluOut = opA ^ opB;
            ALU_SRL: aluOut = opA >> shamt;
            ALU_SRA: aluOut = $unsigned($signed(opA) >>> shamt);
            ALU_OR:  aluOut = opA | opB;
            ALU_AND: aluOut = opA & opB;
            default: aluOut = opA + opB;
        endcase
    end

    always_comb begin
        exMemNext.regWrite  = idEx.ctrl.regWrite;
        exMemNext.memToReg  = idEx.ctrl.memToReg;
        exMemNext.memRead   = idEx.ctrl.memRead;
        exMemNext.memWrite  = idEx.ctrl.memWrite;
        exMemNext.aluOut    = aluOut;
        exMemNext.storeData = byteSwap(idEx.rdata2);
        exMemNext.rd        = idEx.rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (!stall) begin
            exMem <= exMemNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/memWriteback.sv ====
// Memory and writeback: data port request, load capture, memory/writeback register, result select
`timescale 1ns/1ps
`default_nettype none

module memWriteback (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        stall,
    input  wire rvCorePkg::exMemReg_t  exMem,
    output rvCorePkg::dataReq_t        dReq,
    input  wire  [rvCorePkg::XLEN-1:0] dRdata,
    output rvCorePkg::wbPort_t         wb
);
    import rvCorePkg::*;

    memWbReg_t memWb;
    memWbReg_t memWbNext;

    // Request straight from the execute/memory register
    assign dReq.ren   = exMem.memRead;
    // Write only on the edge where the pipe moves on, so it lands once
    assign dReq.wen   = exMem.memWrite & ~stall;
    assign dReq.addr  = exMem.aluOut[XLEN-1:2];
    assign dReq.wdata = exMem.storeData;

    always_comb begin
        memWbNext.regWrite = exMem.regWrite;
        memWbNext.memToReg = exMem.memToReg;
        memWbNext.aluOut   = exMem.aluOut;
        memWbNext.loadData = dRdata;
        memWbNext.rd       = exMem.rd;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWb <= '0;
        end else if (!stall) begin
            memWb <= memWbNext;
        end
    end

    // Load data kept in memory order until here
    assign wb.en   = memWb.regWrite;
    assign wb.addr = memWb.rd;
    assign wb.data = memWb.memToReg ? byteSwap(memWb.loadData) : memWb.aluOut;

endmodule

`default_nettype wire

// ==== src/rvPipelineTop.sv ====
// Pipeline top level: global stall and wiring of fetch, decode, execute and memory/writeback
`timescale 1ns/1ps
`default_nettype none

module rvPipelineTop (
    input  wire                               clk,
    input  wire                               rst_n,
    output logic [rvCorePkg::WORD_ADDR_W-1:0] iAddr,
    input  wire  [rvCorePkg::XLEN-1:0]        iRdata,
    input  wire                               iStall,
    output rvCorePkg::dataReq_t               dReq,
    input  wire  [rvCorePkg::XLEN-1:0]        dRdata,
    input  wire                               dStall
);
    import rvCorePkg::*;

    logic      stall;
    instWord_u instWord;
    idExReg_t  idEx;
    exMemReg_t exMem;
    wbPort_t   wb;

    // Either port stalling freezes the whole pipe
    assign stall = iStall | dStall;

    fetchStage uFetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .iAddr    (iAddr),
        .iRdata   (iRdata),
        .instWord (instWord)
    );

    decodeStage uDecode (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .instWord (instWord),
        .wb       (wb),
        .idEx     (idEx)
    );

    executeStage uExecute (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .idEx  (idEx),
        .exMem (exMem)
    );

    memWriteback uMemWb (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .exMem  (exMem),
        .dReq   (dReq),
        .dRdata (dRdata),
        .wb     (wb)
    );

endmodule

`default_nettype wire

// ==== testbench/storeChecker.sv ====
// Store checker: fetch address sequence and accepted data writes against expected values
`timescale 1ns/1ps
`default_nettype none

module storeChecker (
    input wire                              clk,
    input wire                              rst_n,
    input wire [rvCorePkg::WORD_ADDR_W-1:0] iAddr,
    input wire                              iStall,
    input wire                              dStall,
    input wire rvCorePkg::dataReq_t         dReq
);
    localparam int MAX_TESTS = 32;

    string                             expName [0:MAX_TESTS-1];
    logic [31:0]                       expData [0:MAX_TESTS-1];
    int                                numTests   = 0;
    int                                nextIdx    = 0;
    int                                passCount  = 0;
    int                                failCount  = 0;
    logic                              firstCycle = 1'b1;
    logic                              prevStall;
    logic [rvCorePkg::WORD_ADDR_W-1:0] prevAddr;

    task automatic setExpect(input int idx, input string name, input logic [31:0] value);
        expName[idx] = name;
        expData[idx] = value;
        if (idx >= numTests) begin
            numTests = idx + 1;
        end
    endtask

    // Stores must arrive once each, in table order
    task automatic checkWrite();
        int idx;
        idx = int'(dReq.addr);
        if (idx != nextIdx || idx >= numTests) begin
            $display("Unexpected store to word %0d, word %0d was due next", idx, nextIdx);
            failCount++;
        end else if (dReq.wdata !== expData[idx]) begin
            $display("ERROR %s expected %h actual %h", expName[idx], expData[idx], dReq.wdata);
            failCount++;
        end else begin
            $display("ok    %s wdata=%h", expName[idx], dReq.wdata);
            passCount++;
        end
        nextIdx++;
    endtask

    // ==================================================
    // Sampled on the rising edge, inputs move on the falling edge
    // ==================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            firstCycle = 1'b1;
            nextIdx    = 0;
        end else begin
            if (firstCycle) begin
                if (iAddr !== '0 || dReq.wen !== 1'b0 || dReq.ren !== 1'b0) begin
                    $display("ERROR reset expected %s actual iAddr=%0d wen=%b ren=%b",
                             "iAddr=0 wen=0 ren=0", iAddr, dReq.wen, dReq.ren);
                    failCount++;
                end
            end else if (iAddr !== (prevStall ? prevAddr : prevAddr + 1'b1)) begin
                $display("ERROR iAddr expected %0d actual %0d",
                         prevStall ? prevAddr : prevAddr + 1'b1, iAddr);
                failCount++;
            end
            firstCycle = 1'b0;
            prevAddr   = iAddr;
            prevStall  = iStall | dStall;
            if (dReq.wen && !dStall) begin
                checkWrite();
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tbPipeline.sv ====
// Pipeline testbench: clock, reset, memory models, stall generation, test table, program builder
`timescale 1ns/1ps
`default_nettype none

module tbPipeline;
    import rvCorePkg::*;

    localparam int          NTESTS    = 20;
    localparam int          IMEM_SIZE = 256;
    localparam int          DMEM_SIZE = 64;
    localparam int          LOAD_WORD = 40;
    localparam int          TIMEOUT   = 2000;
    localparam logic [31:0] NOP       = 32'h0000_0013;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [WORD_ADDR_W-1:0] iAddr;
    logic [XLEN-1:0]        iRdata;
    logic                   iStall;
    dataReq_t               dReq;
    logic [XLEN-1:0]        dRdata;
    logic                   dStall;
    logic                   timedOut;
    logic [31:0]            rngState = 32'h9004cdf9;
    logic [31:0]            imem [0:IMEM_SIZE-1];
    logic [31:0]            dmem [0:DMEM_SIZE-1];
    string                  tName [0:NTESTS-1];
    logic [3:0]             tOp [0:NTESTS-1];
    logic [11:0]            tA [0:NTESTS-1];
    logic [11:0]            tB [0:NTESTS-1];
    logic [31:0]            tExp [0:NTESTS-1];
    int                     pc;

    always #5 clk = ~clk;

    rvPipelineTop DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .iAddr  (iAddr),
        .iRdata (iRdata),
        .iStall (iStall),
        .dReq   (dReq),
        .dRdata (dRdata),
        .dStall (dStall)
    );

    storeChecker uStoreChecker (
        .clk    (clk),
        .rst_n  (rst_n),
        .iAddr  (iAddr),
        .iStall (iStall),
        .dStall (dStall),
        .dReq   (dReq)
    );

    function automatic logic [31:0] swapBytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] fillWord(input int addr);
        return 32'h6A09_E667 ^ (addr * 32'h9E37_79B9);
    endfunction

    // RV32I result, op is {instruction bit 30, funct3}
    function automatic logic [31:0] refResult(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            4'h0:    return a + b;
            4'h8:    return a - b;
            4'h2:    return {31'b0, $signed(a) < $signed(b)};
            4'h4:    return a ^ b;
            4'h6:    return a | b;
            4'h7:    return a & b;
            4'h1:    return a << b[4:0];
            4'h5:    return a >> b[4:0];
            4'hD:    return $signed(a) >>> b[4:0];
            default: return 32'hx;
        endcase
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Instruction memory holds big-endian words
    task automatic emit(input logic [31:0] inst);
        imem[pc] = swapBytes(inst);
        pc++;
    endtask

    // ==================================================
    // Test table and program
    // ==================================================
    task automatic buildTable();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] opWord;
        logic [11:0] imm;
        logic [4:0]  src;
        tName = '{"add", "sub", "slt", "xor", "or", "and", "sll", "srl", "sra",
                  "addi", "slti", "xori", "ori", "andi", "slli", "srli", "srai",
                  "srai_neg", "lw_sw", "x0_write"};
        tOp = '{4'h0, 4'h8, 4'h2, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hD,
                4'h0, 4'h2, 4'h4, 4'h6, 4'h7, 4'h1, 4'h5, 4'hD, 4'hD, 4'h0, 4'h0};
        pc = 0;
        for (int i = 0; i < NTESTS; i++) begin
            rngState = xorshift(rngState);
            tA[i] = rngState[11:0];
            tB[i] = rngState[23:12];
            if (i == 17) begin
                tA[i] = 12'hB2E;
                tB[i] = 12'd4;
            end else if (i == 18) begin
                tA[i] = 12'(LOAD_WORD * 4);
            end else if (i == 19) begin
                tA[i] = 12'd77;
            end
            a   = {{20{tA[i][11]}}, tA[i]};
            b   = {{20{tB[i][11]}}, tB[i]};
            src = 5'd3;
            if (i < 9) begin
                opWord = {tOp[i][3] ? 7'h20 : 7'h00, 5'd2, 5'd1, tOp[i][2:0], 5'd3, 7'h33};
                tExp[i] = swapBytes(refResult(tOp[i], a, b));
            end else if (i < 18) begin
                // Shift immediates carry bit 30 above the shift amount
                imm = (tOp[i][1:0] == 2'b01) ? {1'b0, tOp[i][3], 5'b0, tB[i][4:0]} : tB[i];
                opWord = encI(imm, 5'd1, tOp[i][2:0], 5'd3, 7'h13);
                tExp[i] = swapBytes(refResult(tOp[i], a, b));
            end else if (i == 18) begin
                opWord = encI(12'd0, 5'd1, 3'b010, 5'd3, 7'h03);
                tExp[i] = fillWord(LOAD_WORD);
            end else begin
                opWord = encI(tA[i], 5'd0, 3'b000, 5'd0, 7'h13);
                src = 5'd0;
                tExp[i] = '0;
            end
            emit(encI(tA[i], 5'd0, 3'b000, 5'd1, 7'h13));
            emit(encI(tB[i], 5'd0, 3'b000, 5'd2, 7'h13));
            repeat (3) emit(NOP);
            emit(opWord);
            repeat (3) emit(NOP);
            imm = 12'(i * 4);
            emit({imm[11:5], src, 5'd0, 3'b010, imm[4:0], 7'h23});
        end
    endtask

    // Both memories answer in the same cycle, nops past the program
    // Data memory drives read data only for a read request
    assign iRdata = (iAddr < pc) ? imem[iAddr] : swapBytes(NOP);
    assign dRdata = (dReq.ren && dReq.addr < DMEM_SIZE) ? dmem[dReq.addr] : '0;

    always @(posedge clk) begin
        if (dReq.wen && !dStall && dReq.addr < DMEM_SIZE) begin
            dmem[dReq.addr] <= dReq.wdata;
        end
    end

    task automatic runPass(input logic withStalls);
        int    cycles;
        string name;
        for (int i = 0; i < NTESTS; i++) begin
            name = withStalls ? {tName[i], " (stalls)"} : tName[i];
            uStoreChecker.setExpect(i, name, tExp[i]);
        end
        rst_n  = 1'b0;
        iStall = 1'b0;
        dStall = 1'b0;
        repeat (2) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (uStoreChecker.nextIdx < NTESTS && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (withStalls) begin
                rngState = xorshift(rngState);
                iStall = (rngState[2:0] == 3'd0);
                dStall = (rngState[10:8] == 3'd0);
            end
        end
        iStall = 1'b0;
        dStall = 1'b0;
        if (uStoreChecker.nextIdx < NTESTS) begin
            $display("Timeout: only %0d of %0d stores seen after %0d cycles",
                     uStoreChecker.nextIdx, NTESTS, TIMEOUT);
            timedOut = 1'b1;
        end else begin
            // Room for any stray store after the last one
            repeat (20) @(negedge clk);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        iStall   = 1'b0;
        dStall   = 1'b0;
        timedOut = 1'b0;
        for (int k = 0; k < DMEM_SIZE; k++) begin
            dmem[k] = fillWord(k);
        end
        buildTable();
        @(negedge clk);
        runPass(1'b0);
        if (!timedOut) begin
            runPass(1'b1);
        end
        $display("Results: %0d passed, %0d failed", uStoreChecker.passCount,
                 uStoreChecker.failCount);
        if (timedOut || uStoreChecker.failCount != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
src/rvCorePkg.sv
src/fetchStage.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memWriteback.sv
src/rvPipelineTop.sv
testbench/storeChecker.sv
testbench/tbPipeline.sv
